// ==== hdl/vga_pkg.sv ====
package vga_pkg;

  // Video memory word address and data
  localparam int ADDR_W = 20;
  localparam int DATA_W = 16;

  // Pixel and palette sizes
  localparam int PIX_W        = 4;
  localparam int PIX_PER_WORD = 4;
  localparam int PHASE_W      = $clog2(PIX_PER_WORD);
  localparam int COLOR_W      = 12;

  // One burst is one cache line
  localparam int BURST_LEN = 8;
  localparam int BEAT_W    = $clog2(BURST_LEN);

  // Word FIFO, also the initial credit count
  localparam int FIFO_DEPTH = 32;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  // Holds 0 to FIFO_DEPTH inclusive
  localparam int CRED_W     = $clog2(FIFO_DEPTH + 1);

  // Timing counters and config values
  localparam int CNT_W = 10;

  // Clocks per pixel tick
  localparam int PCLK_DIV = 4;
  localparam int DIV_W    = $clog2(PCLK_DIV);

  // Fetch controller states
  typedef enum logic [2:0] {
    FS_IDLE,
    FS_TRY_CACHE,
    FS_CACHE_BEAT,
    FS_FML_REQ,
    FS_FML_BEAT
  } fetch_state_t;

endpackage

// ==== hdl/vga_ifs.sv ====
// Word path from fetch through FIFO to pixel sequencer
interface vga_word_if import vga_pkg::*; ();

  logic              push;
  logic [DATA_W-1:0] push_data;
  logic              pop;
  logic [DATA_W-1:0] pop_data;
  // One pulse per accepted pop
  logic              credit;

  modport producer (output push, output push_data, input credit);
  modport store (
    input  push,
    input  push_data,
    input  pop,
    output pop_data,
    output credit
  );
  // Credit seen here too, a missing one flags underflow
  modport consumer (output pop, input pop_data, input credit);

endinterface

// CRTC timing into the pixel sequencer, valid while tick is high
interface vga_timing_if;

  logic tick;
  logic hsync;
  logic vsync;
  logic de;

  modport source (output tick, output hsync, output vsync, output de);
  modport sink (input tick, input hsync, input vsync, input de);

endinterface

// ==== hdl/vga_crtc.sv ====
module vga_crtc import vga_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [CNT_W-1:0] h_active_i,
  input  logic [CNT_W-1:0] h_total_i,
  input  logic [CNT_W-1:0] h_sync_start_i,
  input  logic [CNT_W-1:0] h_sync_end_i,
  input  logic [CNT_W-1:0] v_active_i,
  input  logic [CNT_W-1:0] v_total_i,
  input  logic [CNT_W-1:0] v_sync_start_i,
  input  logic [CNT_W-1:0] v_sync_end_i,
  vga_timing_if.source     tim
);

  logic [DIV_W-1:0] div_cnt;
  logic             div_last;
  logic [CNT_W-1:0] h_cnt;
  logic [CNT_W-1:0] v_cnt;
  logic             h_wrap;
  logic             v_wrap;

  // Last clock of a pixel period
  assign div_last = (div_cnt == DIV_W'(PCLK_DIV - 1));
  assign h_wrap   = (h_cnt == h_total_i - CNT_W'(1));
  assign v_wrap   = (v_cnt == v_total_i - CNT_W'(1));

  // Pixel tick divider
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else if (div_last) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + DIV_W'(1);
    end
  end

  // Position counters
  // Start in first blanking line so fetch can run ahead
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= v_active_i;
    end else if (div_last) begin
      if (h_wrap) begin
        h_cnt <= '0;
        v_cnt <= v_wrap ? '0 : v_cnt + CNT_W'(1);
      end else begin
        h_cnt <= h_cnt + CNT_W'(1);
      end
    end
  end

  // Outputs registered from the current position
  // They land in the same clock as tick
  always_ff @(posedge clk) begin
    if (rst) begin
      tim.tick  <= 1'b0;
      tim.hsync <= 1'b0;
      tim.vsync <= 1'b0;
      tim.de    <= 1'b0;
    end else begin
      tim.tick <= div_last;
      if (div_last) begin
        tim.hsync <= (h_cnt >= h_sync_start_i) && (h_cnt < h_sync_end_i);
        tim.vsync <= (v_cnt >= v_sync_start_i) && (v_cnt < v_sync_end_i);
        tim.de    <= (h_cnt < h_active_i) && (v_cnt < v_active_i);
      end
    end
  end

endmodule

// ==== hdl/vga_fetch_ctrl.sv ====
module vga_fetch_ctrl import vga_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [ADDR_W-1:0] base_addr_i,
  input  logic [CNT_W-1:0]  h_active_i,
  input  logic [CNT_W-1:0]  v_active_i,
  output logic [ADDR_W-1:0] fml_adr_o,
  output logic              fml_stb_o,
  input  logic              fml_ack_i,
  input  logic [DATA_W-1:0] fml_di_i,
  output logic              dcb_stb_o,
  output logic [ADDR_W-1:0] dcb_adr_o,
  input  logic [DATA_W-1:0] dcb_dat_i,
  input  logic              dcb_hit_i,
  vga_word_if.producer      wq
);

  fetch_state_t      state;
  fetch_state_t      state_d;
  logic [BEAT_W-1:0] idx;
  logic [CRED_W-1:0] credits;
  logic [ADDR_W-1:0] base_q;
  logic [ADDR_W-1:0] word_cnt;
  logic [ADDR_W-1:0] frame_words;
  logic [ADDR_W-1:0] line_adr;
  logic              push_d;
  logic              from_cache;
  logic              burst_done;
  logic              last_beat;
  logic              push_q;
  logic [DATA_W-1:0] push_data_q;

  // Words in one frame
  assign frame_words = ADDR_W'(h_active_i / PIX_PER_WORD) * ADDR_W'(v_active_i);
  assign line_adr    = base_q + word_cnt;
  assign last_beat   = (idx == BEAT_W'(BURST_LEN - 1));

  assign fml_adr_o = line_adr;
  assign fml_stb_o = (state == FS_FML_REQ);
  // Strobe kept high over the whole line so the cache holds it
  assign dcb_stb_o = (state == FS_TRY_CACHE) || (state == FS_CACHE_BEAT);
  assign dcb_adr_o = line_adr + ADDR_W'(idx);

  assign wq.push      = push_q;
  assign wq.push_data = push_data_q;

  always_comb begin
    state_d    = state;
    push_d     = 1'b0;
    from_cache = 1'b0;
    burst_done = 1'b0;
    case (state)
      FS_IDLE: begin
        // Room for a full line
        if (credits >= CRED_W'(BURST_LEN)) state_d = FS_TRY_CACHE;
      end
      FS_TRY_CACHE: begin
        // First word hit means the line hits
        if (dcb_hit_i) begin
          push_d     = 1'b1;
          from_cache = 1'b1;
          state_d    = FS_CACHE_BEAT;
        end else begin
          state_d = FS_FML_REQ;
        end
      end
      FS_CACHE_BEAT: begin
        push_d     = 1'b1;
        from_cache = 1'b1;
        if (last_beat) begin
          burst_done = 1'b1;
          state_d    = FS_IDLE;
        end
      end
      FS_FML_REQ: begin
        if (fml_ack_i) state_d = FS_FML_BEAT;
      end
      FS_FML_BEAT: begin
        // Beats come on back to back clocks after ack
        push_d = 1'b1;
        if (last_beat) begin
          burst_done = 1'b1;
          state_d    = FS_IDLE;
        end
      end
      default: state_d = FS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= FS_IDLE;
      idx      <= '0;
      credits  <= CRED_W'(FIFO_DEPTH);
      push_q   <= 1'b0;
      word_cnt <= '0;
      base_q   <= base_addr_i;
    end else begin
      state  <= state_d;
      push_q <= push_d;
      // Spent when the push is decided, so IDLE sees the true count
      credits <= credits - CRED_W'(push_d) + CRED_W'(wq.credit);
      case (state)
        FS_TRY_CACHE: idx <= BEAT_W'(1);
        FS_CACHE_BEAT, FS_FML_BEAT: idx <= idx + BEAT_W'(1);
        default: idx <= '0;
      endcase
      // Next line, new base only at frame wrap
      if (burst_done) begin
        if (word_cnt + ADDR_W'(BURST_LEN) >= frame_words) begin
          word_cnt <= '0;
          base_q   <= base_addr_i;
        end else begin
          word_cnt <= word_cnt + ADDR_W'(BURST_LEN);
        end
      end
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (push_d) push_data_q <= from_cache ? dcb_dat_i : fml_di_i;
  end

endmodule

// ==== hdl/vga_word_fifo.sv ====
module vga_word_fifo import vga_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  vga_word_if.store wq
);

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [CRED_W-1:0]  count;
  logic               wr_ok;
  logic               rd_ok;

  // Credits keep pushes within space, full check is a guard
  assign wr_ok = wq.push && (count != CRED_W'(FIFO_DEPTH));
  // Pop on empty is dropped
  assign rd_ok = wq.pop && (count != '0);

  // Head word visible without a pop
  assign wq.pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      wq.credit <= 1'b0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + FIFO_AW'(1);
      if (rd_ok) rd_ptr <= rd_ptr + FIFO_AW'(1);
      count <= count + CRED_W'(wr_ok) - CRED_W'(rd_ok);
      // Slot freed, hand it back one clock later
      wq.credit <= rd_ok;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr_ok) mem[wr_ptr] <= wq.push_data;
  end

endmodule

// ==== hdl/vga_pixel_seq.sv ====
module vga_pixel_seq import vga_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  vga_timing_if.sink         tim,
  vga_word_if.consumer       wq,
  input  logic               pal_we_i,
  input  logic [PIX_W-1:0]   pal_addr_i,
  input  logic [COLOR_W-1:0] pal_data_i,
  output logic [3:0]         red_o,
  output logic [3:0]         green_o,
  output logic [3:0]         blue_o,
  output logic               hsync_o,
  output logic               vsync_o,
  output logic               de_o,
  output logic               pclk_en_o,
  output logic               underflow_o
);

  logic [COLOR_W-1:0] pal [2**PIX_W];
  logic [PHASE_W-1:0] phase;
  logic [PIX_W-1:0]   pix_idx;
  logic               pix_en;
  logic               pop_pend;
  logic [COLOR_W-1:0] color_q;

  // Active pixel this clock
  assign pix_en = tim.tick && tim.de;
  // Lowest nibble goes out first
  assign pix_idx = wq.pop_data[phase*PIX_W +: PIX_W];
  // Word done after its last pixel
  assign wq.pop = pix_en && (phase == PHASE_W'(PIX_PER_WORD - 1));

  // 4-4-4 color split
  assign red_o   = color_q[11:8];
  assign green_o = color_q[7:4];
  assign blue_o  = color_q[3:0];

  // Palette RAM
  always_ff @(posedge clk) begin
    if (pal_we_i) pal[pal_addr_i] <= pal_data_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase       <= '0;
      pop_pend    <= 1'b0;
      underflow_o <= 1'b0;
      hsync_o     <= 1'b0;
      vsync_o     <= 1'b0;
      de_o        <= 1'b0;
      pclk_en_o   <= 1'b0;
      color_q     <= '0;
    end else begin
      pclk_en_o <= tim.tick;
      pop_pend  <= wq.pop;
      if (pix_en) phase <= phase + PHASE_W'(1);
      // Pop with no credit back means the FIFO was empty
      if (pop_pend && !wq.credit) underflow_o <= 1'b1;
      // Color and syncs move together on the tick
      if (tim.tick) begin
        hsync_o <= tim.hsync;
        vsync_o <= tim.vsync;
        de_o    <= tim.de;
        color_q <= tim.de ? pal[pix_idx] : '0;
      end
    end
  end

endmodule

// ==== hdl/vga_lcd.sv ====
module vga_lcd import vga_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic [ADDR_W-1:0]  base_addr_i,
  // Timing config
  input  logic [CNT_W-1:0]   h_active_i,
  input  logic [CNT_W-1:0]   h_total_i,
  input  logic [CNT_W-1:0]   h_sync_start_i,
  input  logic [CNT_W-1:0]   h_sync_end_i,
  input  logic [CNT_W-1:0]   v_active_i,
  input  logic [CNT_W-1:0]   v_total_i,
  input  logic [CNT_W-1:0]   v_sync_start_i,
  input  logic [CNT_W-1:0]   v_sync_end_i,
  // Palette write
  input  logic               pal_we_i,
  input  logic [PIX_W-1:0]   pal_addr_i,
  input  logic [COLOR_W-1:0] pal_data_i,
  // Memory bus
  output logic [ADDR_W-1:0]  fml_adr_o,
  output logic               fml_stb_o,
  input  logic               fml_ack_i,
  input  logic [DATA_W-1:0]  fml_di_i,
  // Direct cache bus
  output logic               dcb_stb_o,
  output logic [ADDR_W-1:0]  dcb_adr_o,
  input  logic [DATA_W-1:0]  dcb_dat_i,
  input  logic               dcb_hit_i,
  // Panel side
  output logic [3:0]         red_o,
  output logic [3:0]         green_o,
  output logic [3:0]         blue_o,
  output logic               hsync_o,
  output logic               vsync_o,
  output logic               de_o,
  output logic               pclk_en_o,
  output logic               underflow_o
);

  vga_word_if   wq ();
  vga_timing_if tim ();

  vga_crtc u_crtc (
    .clk(clk), .rst(rst),
    .h_active_i(h_active_i), .h_total_i(h_total_i),
    .h_sync_start_i(h_sync_start_i), .h_sync_end_i(h_sync_end_i),
    .v_active_i(v_active_i), .v_total_i(v_total_i),
    .v_sync_start_i(v_sync_start_i), .v_sync_end_i(v_sync_end_i),
    .tim(tim.source)
  );

  vga_fetch_ctrl u_fetch (
    .clk(clk), .rst(rst),
    .base_addr_i(base_addr_i), .h_active_i(h_active_i), .v_active_i(v_active_i),
    .fml_adr_o(fml_adr_o), .fml_stb_o(fml_stb_o),
    .fml_ack_i(fml_ack_i), .fml_di_i(fml_di_i),
    .dcb_stb_o(dcb_stb_o), .dcb_adr_o(dcb_adr_o),
    .dcb_dat_i(dcb_dat_i), .dcb_hit_i(dcb_hit_i),
    .wq(wq.producer)
  );

  vga_word_fifo u_fifo (.clk(clk), .rst(rst), .wq(wq.store));

  vga_pixel_seq u_seq (
    .clk(clk), .rst(rst),
    .tim(tim.sink), .wq(wq.consumer),
    .pal_we_i(pal_we_i), .pal_addr_i(pal_addr_i), .pal_data_i(pal_data_i),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o),
    .pclk_en_o(pclk_en_o), .underflow_o(underflow_o)
  );

endmodule

// ==== sim/vga_clk_gen.sv ====
// Free running clock and a reset held for the first few cycles
module vga_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Released just after a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

// ==== sim/vga_tb.sv ====
module vga_tb import vga_pkg::*; ();

  // Test display geometry
  localparam int H_ACTIVE = 32;
  localparam int H_TOTAL  = 48;
  localparam int HS_START = 36;
  localparam int HS_END   = 42;
  localparam int V_ACTIVE = 8;
  localparam int V_TOTAL  = 12;
  localparam int VS_START = 9;
  localparam int VS_END   = 10;
  localparam int FRAME_CLKS      = H_TOTAL * V_TOTAL * PCLK_DIV;
  localparam int TIMEOUT_CLKS    = 5 * FRAME_CLKS + 1024;
  localparam int LINES_PER_FRAME = H_ACTIVE * V_ACTIVE / PIX_PER_WORD / BURST_LEN;
  // Palette and base rewritten in the blanking after this frame
  localparam int CHANGE_FRAME = 2;
  localparam int LAST_FRAME   = 4;
  localparam logic [ADDR_W-1:0] BASE0 = 20'h12340;
  localparam logic [ADDR_W-1:0] BASE1 = 20'h8f0c8;

  logic               clk;
  logic               rst;
  logic [ADDR_W-1:0]  base_addr_i;
  logic [CNT_W-1:0]   h_active_i, h_total_i, h_sync_start_i, h_sync_end_i;
  logic [CNT_W-1:0]   v_active_i, v_total_i, v_sync_start_i, v_sync_end_i;
  logic               pal_we_i;
  logic [PIX_W-1:0]   pal_addr_i;
  logic [COLOR_W-1:0] pal_data_i;
  logic [ADDR_W-1:0]  fml_adr_o;
  logic               fml_stb_o;
  logic               fml_ack_i;
  logic [DATA_W-1:0]  fml_di_i;
  logic               dcb_stb_o;
  logic [ADDR_W-1:0]  dcb_adr_o;
  logic [DATA_W-1:0]  dcb_dat_i;
  logic               dcb_hit_i;
  logic [3:0]         red_o, green_o, blue_o;
  logic               hsync_o, vsync_o, de_o, pclk_en_o, underflow_o;

  // Palettes before and after the rewrite
  logic [COLOR_W-1:0] pal0 [2**PIX_W];
  logic [COLOR_W-1:0] pal1 [2**PIX_W];

  // Display position from the first blanking line
  int   h_pos    = 0;
  int   v_pos    = V_ACTIVE;
  int   frame_no = -1;
  int   pixels   = 0;
  // Fetch bookkeeping
  int   bursts         = 0;
  int   cache_words    = 0;
  int   mem_words      = 0;
  int   acks           = 0;
  int   cache_mark     = 0;
  int   ack_mark       = 0;
  int   frames_checked = 0;
  logic stb_prev       = 1'b0;
  logic beat_on;
  int   checks = 0;
  int   errors = 0;
  int   cycles = 0;
  logic done   = 1'b0;

  vga_clk_gen #(.PERIOD(8), .RST_CYCLES(3)) u_clk_gen (.clk_o(clk), .rst_o(rst));

  vga_lcd UUT (
    .clk(clk), .rst(rst), .base_addr_i(base_addr_i),
    .h_active_i(h_active_i), .h_total_i(h_total_i),
    .h_sync_start_i(h_sync_start_i), .h_sync_end_i(h_sync_end_i),
    .v_active_i(v_active_i), .v_total_i(v_total_i),
    .v_sync_start_i(v_sync_start_i), .v_sync_end_i(v_sync_end_i),
    .pal_we_i(pal_we_i), .pal_addr_i(pal_addr_i), .pal_data_i(pal_data_i),
    .fml_adr_o(fml_adr_o), .fml_stb_o(fml_stb_o), .fml_ack_i(fml_ack_i), .fml_di_i(fml_di_i),
    .dcb_stb_o(dcb_stb_o), .dcb_adr_o(dcb_adr_o), .dcb_dat_i(dcb_dat_i), .dcb_hit_i(dcb_hit_i),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o),
    .pclk_en_o(pclk_en_o), .underflow_o(underflow_o)
  );

  // Video memory contents from the whole address
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] adr);
    logic [ADDR_W-1:0] prod;
    prod = adr * ADDR_W'(20'h09e5b);
    return prod[DATA_W-1:0] ^ {adr[3:0], adr[ADDR_W-1:8]};
  endfunction

  // New base reaches fetch only after the next frame wrap
  function automatic logic [ADDR_W-1:0] base_of_frame(input int frame);
    return (frame >= CHANGE_FRAME + 2) ? BASE1 : BASE0;
  endfunction

  // Expected color of pixel k in a frame
  function automatic logic [COLOR_W-1:0] ref_color(input int frame, input int k);
    logic [DATA_W-1:0] w;
    logic [PIX_W-1:0]  idx;
    w   = mem_word(base_of_frame(frame) + ADDR_W'(k / PIX_PER_WORD));
    idx = w[(k % PIX_PER_WORD) * PIX_W +: PIX_W];
    // Palette is live right away
    return (frame > CHANGE_FRAME) ? pal1[idx] : pal0[idx];
  endfunction

  // Lines of one frame that the cache holds
  function automatic int hit_lines(input logic [ADDR_W-1:0] base);
    logic [ADDR_W-1:0] line;
    int                n;
    n = 0;
    for (int i = 0; i < LINES_PER_FRAME; i++) begin
      line = base + ADDR_W'(i * BURST_LEN);
      if (line[3]) n++;
    end
    return n;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic load_palette(input bit use_new);
    for (int i = 0; i < 2**PIX_W; i++) begin
      @(posedge clk);
      #1;
      pal_we_i   = 1'b1;
      pal_addr_i = PIX_W'(i);
      pal_data_i = use_new ? pal1[i] : pal0[i];
    end
    @(posedge clk);
    #1;
    pal_we_i = 1'b0;
  endtask

  // Cache answers in the same clock
  // Line hits when address bit 3 is set
  assign dcb_hit_i = dcb_stb_o && dcb_adr_o[3];
  // A miss returns the inverted word
  assign dcb_dat_i = dcb_hit_i ? mem_word(dcb_adr_o) : ~mem_word(dcb_adr_o);

  // Memory bus with random ack delay then 8 back to back beats
  initial begin : mem_model
    int                delay;
    logic [ADDR_W-1:0] req_adr;
    fml_ack_i = 1'b0;
    fml_di_i  = '0;
    beat_on   = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (!rst && fml_stb_o) begin
        req_adr = fml_adr_o;
        delay   = $urandom_range(20, 0);
        repeat (delay) @(posedge clk);
        #1;
        fml_ack_i = 1'b1;
        acks++;
        @(posedge clk);
        #1;
        fml_ack_i = 1'b0;
        for (int j = 0; j < BURST_LEN; j++) begin
          fml_di_i = mem_word(req_adr + ADDR_W'(j));
          beat_on  = 1'b1;
          @(posedge clk);
          #1;
        end
        beat_on = 1'b0;
      end
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin : compare
    logic              exp_de;
    logic [ADDR_W-1:0] line_exp;
    int                fetch_frame;
    int                exp_hits;
    if (!rst) begin
      if (pclk_en_o) begin
        exp_de = (h_pos < H_ACTIVE) && (v_pos < V_ACTIVE);
        check_value("hsync_o", 32'(hsync_o), 32'((h_pos >= HS_START) && (h_pos < HS_END)));
        check_value("vsync_o", 32'(vsync_o), 32'((v_pos >= VS_START) && (v_pos < VS_END)));
        check_value("de_o", 32'(de_o), 32'(exp_de));
        if (exp_de) begin
          check_value("pixel color", 32'({red_o, green_o, blue_o}),
                      32'(ref_color(frame_no, v_pos * H_ACTIVE + h_pos)));
        end else begin
          check_value("blank color", 32'({red_o, green_o, blue_o}), 32'd0);
        end
        // Pixels the DUT marks active
        if (de_o) pixels++;
        // Step own position counters
        if (h_pos == H_TOTAL - 1) begin
          h_pos = 0;
          if (v_pos == V_TOTAL - 1) begin
            v_pos = 0;
            frame_no++;
          end else begin
            v_pos++;
          end
        end else begin
          h_pos++;
        end
        // Last frame fully shown
        if (frame_no == LAST_FRAME && v_pos == V_ACTIVE && h_pos == 0) begin
          check_value("underflow_o", 32'(underflow_o), 32'd0);
          check_value("pixels shown", 32'(pixels), 32'((LAST_FRAME + 1) * H_ACTIVE * V_ACTIVE));
          check_value("fetch frames checked", 32'(frames_checked), 32'(LAST_FRAME + 1));
          done = 1'b1;
        end
      end
      // New burst closes out the previous frame at a frame boundary
      if (dcb_stb_o && !stb_prev) begin
        fetch_frame = bursts / LINES_PER_FRAME;
        if ((bursts % LINES_PER_FRAME == 0) && (bursts > 0)) begin
          exp_hits = hit_lines(base_of_frame(fetch_frame - 1));
          check_value("cache words in frame", 32'(cache_words - cache_mark),
                      32'(exp_hits * BURST_LEN));
          check_value("memory acks in frame", 32'(acks - ack_mark),
                      32'(LINES_PER_FRAME - exp_hits));
          cache_mark = cache_words;
          ack_mark   = acks;
          frames_checked++;
        end
        line_exp = base_of_frame(fetch_frame)
                 + ADDR_W'(BURST_LEN * (bursts % LINES_PER_FRAME));
        check_value("line address", 32'(dcb_adr_o), 32'(line_exp));
        bursts++;
      end
      stb_prev = dcb_stb_o;
      if (dcb_stb_o && dcb_hit_i) cache_words++;
      if (beat_on) mem_words++;
      // Words in flight never more than the FIFO holds
      check_value("words ahead over depth",
                  32'((cache_words + mem_words - pixels / PIX_PER_WORD) > FIFO_DEPTH), 32'd0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CLKS) begin
      $display("Timeout after %0d clocks, frame %0d never finished", cycles, LAST_FRAME);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hd7c2));
    for (int i = 0; i < 2**PIX_W; i++) begin
      pal0[i] = COLOR_W'($urandom);
      pal1[i] = COLOR_W'($urandom);
    end
    base_addr_i    = BASE0;
    h_active_i     = CNT_W'(H_ACTIVE);
    h_total_i      = CNT_W'(H_TOTAL);
    h_sync_start_i = CNT_W'(HS_START);
    h_sync_end_i   = CNT_W'(HS_END);
    v_active_i     = CNT_W'(V_ACTIVE);
    v_total_i      = CNT_W'(V_TOTAL);
    v_sync_start_i = CNT_W'(VS_START);
    v_sync_end_i   = CNT_W'(VS_END);
    pal_we_i       = 1'b0;
    pal_addr_i     = '0;
    pal_data_i     = '0;
    @(negedge rst);
    // First blanking lines leave time for this
    load_palette(1'b0);
    wait (frame_no == CHANGE_FRAME && v_pos == V_ACTIVE);
    load_palette(1'b1);
    base_addr_i = BASE1;
    wait (done);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
hdl/vga_pkg.sv
hdl/vga_ifs.sv
hdl/vga_crtc.sv
hdl/vga_fetch_ctrl.sv
hdl/vga_word_fifo.sv
hdl/vga_pixel_seq.sv
hdl/vga_lcd.sv
sim/vga_clk_gen.sv
sim/vga_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the vga_lcd testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 --top-module vga_tb -Mdir "$OBJ" -o vga_sim -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ/vga_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only if the log holds the pass line
if grep -q "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
